//--- event_recorder.sv
// event_recorder: turns rule matches and idle time into record words and a trigger pulse
`timescale 1ns/1ps

module event_recorder #(
  parameter int MATCH_RULES = 8,
  parameter int DELTA_WIDTH = 13
) (
  input  logic                   fe_clk,
  input  logic                   reset,
  input  logic [MATCH_RULES-1:0] match_vec,
  input  logic                   arm,
  input  logic                   arm_start,
  input  logic [MATCH_RULES-1:0] trig_enable,
  output logic                   rec_wr,
  output trace_pkg::fe_record_t  rec_word,
  output logic                   trig_out
);
  import trace_pkg::*;

  localparam logic [DELTA_WIDTH-1:0] DELTA_MAX = '1;

  logic [DELTA_WIDTH-1:0]   delta_cnt;
  logic [REC_RULE_BITS-1:0] low_rule;
  logic                     any_match;
  logic                     delta_full;
  logic                     trig_hit;
  fe_record_t               next_word;

  assign any_match  = arm && (|match_vec);
  assign delta_full = arm && (delta_cnt == DELTA_MAX);
  assign trig_hit   = arm && (|(match_vec & trig_enable));

  // lowest index wins when several rules hit together
  always_comb begin
    low_rule = '0;
    for (int i = MATCH_RULES - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        low_rule = REC_RULE_BITS'(i);
      end
    end
  end

  always_comb begin
    next_word = '0;
    if (any_match) begin
      next_word.mrec.cmd   = REC_MATCH;
      next_word.mrec.rule  = low_rule;
      next_word.mrec.delta = REC_DELTA_BITS'(delta_cnt);
    end else begin
      next_word.trec.cmd   = REC_TIME;
      next_word.trec.stamp = REC_STAMP_BITS'(DELTA_MAX);
    end
  end

  // counts armed cycles, a match takes priority over the time record
  always_ff @(posedge fe_clk) begin
    if (reset || arm_start) begin
      delta_cnt <= '0;
    end else if (any_match) begin
      delta_cnt <= DELTA_WIDTH'(1);  // this cycle is the first one of the next gap
    end else if (delta_full) begin
      delta_cnt <= '0;
    end else if (arm) begin
      delta_cnt <= delta_cnt + 1'b1;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      rec_wr   <= 1'b0;
      trig_out <= 1'b0;
    end else begin
      rec_wr   <= any_match || delta_full;
      trig_out <= trig_hit;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (any_match || delta_full) begin
      rec_word <= next_word;
    end
  end

endmodule

//--- list.f
+incdir+.
trace_pkg.sv
trace_regs.sv
pattern_matcher.sv
event_recorder.sv
record_fifo.sv
trace_top.sv
tb_trace_top.sv

//--- pattern_matcher.sv
// pattern_matcher: trace byte shift buffer, masked rule compare and per-rule match counters
`timescale 1ns/1ps

module pattern_matcher #(
  parameter int BUFFER_BITS = 64,
  parameter int MATCH_RULES = 8
) (
  input  logic                               fe_clk,
  input  logic                               reset,
  input  logic [7:0]                         trace_byte,
  input  logic                               trace_valid,
  input  logic                               arm,
  input  logic [MATCH_RULES-1:0]             rule_enable,
  input  logic [MATCH_RULES*BUFFER_BITS-1:0] patterns,
  input  logic [MATCH_RULES*BUFFER_BITS-1:0] masks,
  output logic [MATCH_RULES-1:0]             match_vec,
  output logic [MATCH_RULES*8-1:0]           match_counts,
  output logic                               arm_start
);

  logic [BUFFER_BITS-1:0] shift_buf;
  logic                   buf_new;    // buffer took a byte on the last edge
  logic                   arm_q;
  logic [MATCH_RULES-1:0] hit;
  logic [7:0]             count_q [MATCH_RULES];

  assign arm_start = arm & ~arm_q;

  // newest byte lands in the low bits
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      shift_buf <= '0;
      buf_new   <= 1'b0;
      arm_q     <= 1'b0;
    end else begin
      if (trace_valid) begin
        shift_buf <= {shift_buf[BUFFER_BITS-9:0], trace_byte};
      end
      buf_new <= trace_valid;
      arm_q   <= arm;
    end
  end

  // only bits under the mask take part in the compare
  always_comb begin
    for (int i = 0; i < MATCH_RULES; i++) begin
      hit[i] = rule_enable[i] &&
               (((shift_buf ^ patterns[i*BUFFER_BITS +: BUFFER_BITS]) &
                 masks[i*BUFFER_BITS +: BUFFER_BITS]) == '0);
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      match_vec <= '0;
    end else begin
      match_vec <= (buf_new && arm) ? hit : '0;  // one look per accepted byte
    end
  end

  // saturating counters, cleared when a capture is armed
  always_ff @(posedge fe_clk) begin
    if (reset || arm_start) begin
      for (int i = 0; i < MATCH_RULES; i++) begin
        count_q[i] <= 8'd0;
      end
    end else if (buf_new && arm) begin
      for (int i = 0; i < MATCH_RULES; i++) begin
        if (hit[i] && count_q[i] != 8'hff) begin
          count_q[i] <= count_q[i] + 8'd1;
        end
      end
    end
  end

  for (genvar g = 0; g < MATCH_RULES; g++) begin : g_count_out
    assign match_counts[g*8 +: 8] = count_q[g];
  end

endmodule

//--- record_fifo.sv
// record_fifo: circular record buffer with valid/ready drain, level and sticky overflow
`timescale 1ns/1ps

module record_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                          fe_clk,
  input  logic                          reset,
  input  logic                          rec_wr,
  input  trace_pkg::fe_record_t         rec_word,
  input  logic                          rec_ready,
  input  logic                          clear_overflow,
  output logic                          rec_valid,
  output logic [17:0]                   rec_data,
  output logic [$clog2(FIFO_DEPTH):0]   fifo_level,
  output logic                          overflow
);
  import trace_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);

  fe_record_t  mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          push;
  logic          pop;

  assign full      = fifo_level == (AW + 1)'(FIFO_DEPTH);
  assign push      = rec_wr && !full;  // dropped when full
  assign pop       = rec_valid && rec_ready;
  assign rec_valid = fifo_level != '0;
  assign rec_data  = mem[rd_ptr];

  always_ff @(posedge fe_clk) begin
    if (push) begin
      mem[wr_ptr] <= rec_word;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_level <= '0;
      overflow   <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap at the power of two
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        fifo_level <= fifo_level + 1'b1;
      end else if (pop && !push) begin
        fifo_level <= fifo_level - 1'b1;
      end
      if (rec_wr && full) begin
        overflow <= 1'b1;
      end else if (clear_overflow) begin
        overflow <= 1'b0;
      end
    end
  end

endmodule

//--- tb_axi_tasks.svh
// tb_axi_tasks: AXI4-Lite register access, trace byte drive and value compare for the testbench
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
  if (got !== expected) begin
    $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
    abort_run();
  end
endtask

// gives up when a handshake signal never shows
task automatic count_wait(inout int waited, input string what);
  waited++;
  if (waited > 20) begin
    $display("no %s from the DUT within 20 cycles", what);
    abort_run();
  end
endtask

task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
  int waited;
  waited = 0;
  @(posedge fe_clk);
  #1;
  awaddr  = addr;
  wdata   = data;
  awvalid = 1'b1;
  wvalid  = 1'b1;
  bready  = 1'b1;
  @(posedge fe_clk);
  #1;
  while (!awready) begin
    count_wait(waited, "awready");
    @(posedge fe_clk);
    #1;
  end
  check_value("wready", wready, 1);  // raised together with awready
  @(posedge fe_clk);  // address and data taken here
  #1;
  awvalid = 1'b0;
  wvalid  = 1'b0;
  while (!bvalid) begin
    count_wait(waited, "bvalid");
    @(posedge fe_clk);
    #1;
  end
  check_value("bresp", bresp, 2'b00);  // OKAY
  @(posedge fe_clk);
  #1;
  bready = 1'b0;
endtask

task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
  int waited;
  waited = 0;
  @(posedge fe_clk);
  #1;
  araddr  = addr;
  arvalid = 1'b1;
  rready  = 1'b1;
  @(posedge fe_clk);
  #1;
  while (!arready) begin
    count_wait(waited, "arready");
    @(posedge fe_clk);
    #1;
  end
  @(posedge fe_clk);
  #1;
  arvalid = 1'b0;
  while (!rvalid) begin
    count_wait(waited, "rvalid");
    @(posedge fe_clk);
    #1;
  end
  data = rdata;
  check_value("rresp", rresp, 2'b00);
  @(posedge fe_clk);
  #1;
  rready = 1'b0;
endtask

// back to back calls give one byte per cycle
task automatic send_byte(input logic [7:0] value);
  @(posedge fe_clk);
  #1;
  trace_byte  = value;
  trace_valid = 1'b1;
endtask

task automatic stop_trace();
  @(posedge fe_clk);  // last byte taken here
  #1;
  trace_valid = 1'b0;
endtask

`endif

//--- tb_trace_top.sv
// tb_trace_top: directed testbench for the trace front end, register setup and record stream checks
`timescale 1ns/1ps

module tb_trace_top;

  localparam int CYCLE_LIMIT = 40000;  // idle test alone takes about 8200
  localparam logic [7:0] CTRL_ADDR    = 8'h00;
  localparam logic [7:0] RULE_EN_ADDR = 8'h04;
  localparam logic [7:0] STATUS_ADDR  = 8'h08;
  localparam logic [7:0] COUNT_ADDR   = 8'h10;
  localparam logic [7:0] RULE_ADDR    = 8'h40;

  logic        fe_clk = 1'b0;
  logic        reset;
  logic [7:0]  trace_byte;
  logic        trace_valid;
  logic        awvalid;
  logic        awready;
  logic [7:0]  awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [7:0]  araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rec_valid;
  logic        rec_ready;
  logic [17:0] rec_data;
  logic        trig_out;

  logic [17:0] rec_q [$];    // drained records, oldest first
  int          trig_count;
  int          cycle_count = 0;

  trace_top uut (
    .fe_clk, .reset, .trace_byte, .trace_valid,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .rec_valid, .rec_ready, .rec_data, .trig_out
  );

  always #5 fe_clk = ~fe_clk;

  // handshake completes on the following rising edge
  always @(negedge fe_clk) begin
    if (!reset && rec_valid && rec_ready) begin
      rec_q.push_back(rec_data);
    end
    if (trig_out) begin
      trig_count++;
    end
  end

  always @(posedge fe_clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout, the run went past %0d clock cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  `include "tb_axi_tasks.svh"

  function automatic logic [7:0] random_filler();
    return 8'($urandom() & 32'h3f);  // below every pattern byte in use
  endfunction

  task automatic send_fillers(input int count);
    repeat (count) send_byte(random_filler());
  endtask

  task automatic wait_cycles(input int count);
    repeat (count) @(posedge fe_clk);
    #1;
  endtask

  task automatic wait_records(input int count, input int limit);
    int waited;
    waited = 0;
    while (rec_q.size() < count) begin
      if (waited == limit) begin
        $display("only %0d of %0d records came out within %0d cycles",
                 rec_q.size(), count, limit);
        abort_run();
      end
      waited++;
      @(posedge fe_clk);
      #1;
    end
  endtask

  task automatic read_compare(input logic [7:0] addr, input logic [31:0] expected,
                              input string name);
    logic [31:0] value;
    axi_read(addr, value);
    check_value(name, value, expected);
  endtask

  task automatic set_rule(input int idx, input logic [63:0] pattern, input logic [63:0] mask);
    logic [7:0] base;
    base = RULE_ADDR + 8'(16 * idx);
    axi_write(base, pattern[31:0]);
    axi_write(base + 8'h4, pattern[63:32]);
    axi_write(base + 8'h8, mask[31:0]);
    axi_write(base + 8'hc, mask[63:32]);
  endtask

  // cmd in [17:16], rule in [15:13], delta below
  task automatic expect_match(input logic [17:0] rec, input int rule);
    check_value("record cmd", rec[17:16], 1);
    check_value("record rule", rec[15:13], rule);
  endtask

  task automatic register_access();
    check_value("trig_out", trig_out, 0);
    check_value("rec_valid", rec_valid, 0);
    check_value("bvalid", bvalid, 0);
    check_value("rvalid", rvalid, 0);
    set_rule(5, 64'h9abc_def0_1234_5678, 64'hf0f0_f0f0_0f0f_0f0f);
    read_compare(8'h90, 32'h1234_5678, "rule 5 pattern low");
    read_compare(8'h94, 32'h9abc_def0, "rule 5 pattern high");
    read_compare(8'h98, 32'h0f0f_0f0f, "rule 5 mask low");
    read_compare(8'h9c, 32'hf0f0_f0f0, "rule 5 mask high");
    axi_write(RULE_EN_ADDR, 32'h0000_a55a);
    read_compare(RULE_EN_ADDR, 32'h0000_a55a, "RULE_EN");
    read_compare(8'h3c, 0, "unmapped 0x3c");
    read_compare(8'h0c, 0, "unmapped 0x0c");
    axi_write(CTRL_ADDR, 32'h2);
    read_compare(CTRL_ADDR, 0, "CTRL");
    read_compare(STATUS_ADDR, 0, "STATUS");
    axi_write(RULE_EN_ADDR, 0);
  endtask

  task automatic masked_match();
    set_rule(2, 64'h0000_dead, 64'h0000_ffff);
    axi_write(RULE_EN_ADDR, 32'h4);
    axi_write(CTRL_ADDR, 32'h1);
    for (int pass = 0; pass < 2; pass++) begin
      rec_q.delete();
      send_fillers(5);
      send_byte(8'hde);
      send_byte(8'had);
      send_fillers(5);
      stop_trace();
      if (pass == 0) begin
        wait_records(1, 20);
        wait_cycles(10);
        check_value("record count", rec_q.size(), 1);
        expect_match(rec_q[0], 2);
        read_compare(COUNT_ADDR + 8'h8, 1, "rule 2 count");
        axi_write(RULE_EN_ADDR, 0);  // same bytes again, rule off
      end else begin
        wait_cycles(10);
        check_value("record count", rec_q.size(), 0);
      end
    end
    axi_write(CTRL_ADDR, 0);
  endtask

  task automatic priority_and_delta();
    int gap;
    gap = 2 + ($urandom() % 20);
    set_rule(1, 64'h5a, 64'hff);
    set_rule(4, 64'h40, 64'hc0);  // top two bits only, 0x5a fits too
    axi_write(RULE_EN_ADDR, 32'h12);
    axi_write(CTRL_ADDR, 32'h1);
    rec_q.delete();
    send_fillers(3);
    send_byte(8'h5a);
    send_fillers(gap - 1);
    send_byte(8'h5a);
    send_fillers(3);
    stop_trace();
    wait_records(2, 20);
    wait_cycles(6);
    check_value("record count", rec_q.size(), 2);
    expect_match(rec_q[0], 1);
    expect_match(rec_q[1], 1);
    check_value("record delta", rec_q[1][12:0], gap);
    read_compare(COUNT_ADDR + 8'h4, 2, "rule 1 count");
    read_compare(COUNT_ADDR + 8'h10, 2, "rule 4 count");
    axi_write(CTRL_ADDR, 0);
  endtask

  task automatic trigger_mask();
    set_rule(0, 64'h66, 64'hff);
    set_rule(3, 64'h77, 64'hff);
    axi_write(RULE_EN_ADDR, 32'h0809);  // rules 0 and 3, trigger on 3 only
    axi_write(CTRL_ADDR, 32'h1);
    rec_q.delete();
    trig_count = 0;
    send_byte(8'h77);
    send_fillers(2);
    send_byte(8'h66);
    send_fillers(2);
    send_byte(8'h77);
    send_byte(8'h66);
    send_fillers(1);
    send_byte(8'h77);
    send_fillers(3);
    stop_trace();
    wait_records(5, 20);
    wait_cycles(6);
    check_value("record count", rec_q.size(), 5);
    for (int n = 0; n < 5; n++) begin
      expect_match(rec_q[n], (n % 2 == 0) ? 3 : 0);
    end
    check_value("trig_out pulses", trig_count, 3);
    axi_write(CTRL_ADDR, 0);
  endtask

  task automatic fifo_overflow();
    axi_write(RULE_EN_ADDR, 32'h02);
    rec_ready = 1'b0;
    axi_write(CTRL_ADDR, 32'h1);
    rec_q.delete();
    for (int n = 0; n < 20; n++) begin
      send_byte(8'h5a);
      send_fillers(n);  // next record then carries delta n + 1
    end
    stop_trace();
    wait_cycles(8);
    read_compare(STATUS_ADDR, 32'h0000_1001, "STATUS");  // level 16 and overflow
    check_value("records while stalled", rec_q.size(), 0);
    rec_ready = 1'b1;
    wait_records(16, 40);
    wait_cycles(4);
    check_value("records drained", rec_q.size(), 16);
    for (int n = 0; n < 16; n++) begin
      expect_match(rec_q[n], 1);
      if (n > 0) begin
        check_value("record delta", rec_q[n][12:0], n);
      end
    end
    axi_write(CTRL_ADDR, 32'h2);  // disarm, clear overflow
    read_compare(STATUS_ADDR, 0, "STATUS");
  endtask

  task automatic idle_and_rearm();
    read_compare(COUNT_ADDR + 8'h4, 20, "rule 1 count");  // kept while disarmed
    axi_write(CTRL_ADDR, 32'h1);
    rec_q.delete();
    wait_records(1, 8300);
    check_value("record cmd", rec_q[0][17:16], 2);
    check_value("record stamp", rec_q[0][15:0], 16'h1fff);
    rec_q.delete();
    send_byte(8'h5a);
    stop_trace();
    wait_records(1, 20);
    expect_match(rec_q[0], 1);
    read_compare(COUNT_ADDR + 8'h4, 1, "rule 1 count");
    axi_write(CTRL_ADDR, 0);
    axi_write(CTRL_ADDR, 32'h1);
    for (int i = 0; i < 8; i++) begin
      read_compare(COUNT_ADDR + 8'(4 * i), 0, "match count after re-arm");
    end
    axi_write(CTRL_ADDR, 0);
  endtask

  initial begin
    void'($urandom(32'h6d2c));  // fixed seed for filler bytes
    reset       = 1'b1;
    trace_byte  = 8'h00;
    trace_valid = 1'b0;
    awvalid     = 1'b0;
    awaddr      = 8'h00;
    wvalid      = 1'b0;
    wdata       = 32'h0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = 8'h00;
    rready      = 1'b0;
    rec_ready   = 1'b1;
    trig_count  = 0;
    repeat (4) @(posedge fe_clk);
    #1;
    reset = 1'b0;
    register_access();
    masked_match();
    priority_and_delta();
    trigger_mask();
    fifo_overflow();
    idle_and_rearm();
    $display("Test OK");
    $finish;
  end

endmodule

//--- trace_pkg.sv
// trace_pkg: record word formats, command codes and register map of the trace front end
package trace_pkg;

  // record field widths, 18 bits per word in total
  localparam int REC_RULE_BITS  = 3;
  localparam int REC_DELTA_BITS = 13;
  localparam int REC_STAMP_BITS = 16;

  // command field of a record word, code 0 is never written
  typedef enum logic [1:0] {
    REC_MATCH = 2'd1,
    REC_TIME  = 2'd2
  } rec_cmd_t;

  typedef struct packed {
    rec_cmd_t                  cmd;
    logic [REC_RULE_BITS-1:0]  rule;   // lowest matched rule
    logic [REC_DELTA_BITS-1:0] delta;  // cycles since previous record
  } match_rec_t;

  typedef struct packed {
    rec_cmd_t                  cmd;
    logic [REC_STAMP_BITS-1:0] stamp;  // idle time covered by this record
  } time_rec_t;

  // cmd sits in the same two top bits of both views
  typedef union packed {
    match_rec_t mrec;
    time_rec_t  trec;
  } fe_record_t;

  // register byte offsets
  localparam logic [7:0] REG_CTRL       = 8'h00;
  localparam logic [7:0] REG_RULE_EN    = 8'h04;
  localparam logic [7:0] REG_STATUS     = 8'h08;
  localparam logic [7:0] REG_COUNT_BASE = 8'h10;  // one word per rule
  localparam logic [7:0] REG_RULE_BASE  = 8'h40;  // four words per rule

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

//--- trace_regs.sv
// trace_regs: AXI4-Lite slave for arm control, rule patterns and masks, and status readback
`timescale 1ns/1ps

module trace_regs #(
  parameter int BUFFER_BITS = 64,
  parameter int MATCH_RULES = 8,
  parameter int FIFO_DEPTH  = 16
) (
  input  logic                               fe_clk,
  input  logic                               reset,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [7:0]                         awaddr,
  input  logic                               wvalid,
  output logic                               wready,
  input  logic [31:0]                        wdata,
  output logic                               bvalid,
  input  logic                               bready,
  output logic [1:0]                         bresp,
  input  logic                               arvalid,
  output logic                               arready,
  input  logic [7:0]                         araddr,
  output logic                               rvalid,
  input  logic                               rready,
  output logic [31:0]                        rdata,
  output logic [1:0]                         rresp,
  input  logic [MATCH_RULES*8-1:0]           match_counts,
  input  logic                               overflow,
  input  logic [$clog2(FIFO_DEPTH):0]        fifo_level,
  output logic                               arm,
  output logic                               clear_overflow,
  output logic [MATCH_RULES-1:0]             rule_enable,
  output logic [MATCH_RULES-1:0]             trig_enable,
  output logic [MATCH_RULES*BUFFER_BITS-1:0] patterns,
  output logic [MATCH_RULES*BUFFER_BITS-1:0] masks
);
  import trace_pkg::*;

  localparam int LEVEL_BITS = $clog2(FIFO_DEPTH) + 1;

  logic [BUFFER_BITS-1:0] pattern_q [MATCH_RULES];
  logic [BUFFER_BITS-1:0] mask_q    [MATCH_RULES];
  logic                   wr_en;
  logic                   rd_en;
  logic [7:0]             wr_rule_off;
  logic [7:0]             rd_rule_off;
  logic [7:0]             rd_cnt_off;
  logic [31:0]            rd_word;

  assign wr_en       = awready & awvalid & wvalid;  // address and data taken together
  assign rd_en       = arready & arvalid;
  assign wr_rule_off = awaddr - REG_RULE_BASE;
  assign rd_rule_off = araddr - REG_RULE_BASE;
  assign rd_cnt_off  = araddr - REG_COUNT_BASE;

  // every access completes without error
  assign bresp = AXI_RESP_OKAY;
  assign rresp = AXI_RESP_OKAY;

  // write channel, one transfer until the response is taken
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= !awready && !bvalid && awvalid && wvalid;
      wready  <= !awready && !bvalid && awvalid && wvalid;
      if (wr_en) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      arm            <= 1'b0;
      clear_overflow <= 1'b0;
      rule_enable    <= '0;
      trig_enable    <= '0;
      for (int i = 0; i < MATCH_RULES; i++) begin
        pattern_q[i] <= '0;
        mask_q[i]    <= '0;
      end
    end else begin
      clear_overflow <= 1'b0;  // single cycle strobe
      if (wr_en) begin
        if (awaddr == REG_CTRL) begin
          arm            <= wdata[0];
          clear_overflow <= wdata[1];
        end
        if (awaddr == REG_RULE_EN) begin
          rule_enable <= wdata[MATCH_RULES-1:0];
          trig_enable <= wdata[8 +: MATCH_RULES];
        end
        for (int i = 0; i < MATCH_RULES; i++) begin
          if (awaddr >= REG_RULE_BASE && wr_rule_off[7:4] == 4'(i)) begin
            case (wr_rule_off[3:2])
              2'd0:    pattern_q[i][31:0]            <= wdata;
              2'd1:    pattern_q[i][BUFFER_BITS-1:32] <= wdata[BUFFER_BITS-33:0];
              2'd2:    mask_q[i][31:0]               <= wdata;
              default: mask_q[i][BUFFER_BITS-1:32]    <= wdata[BUFFER_BITS-33:0];
            endcase
          end
        end
      end
    end
  end

  // readback mux, unmapped offsets give zero
  always_comb begin
    rd_word = '0;
    if (araddr == REG_CTRL) begin
      rd_word[0] = arm;  // bit1 is a strobe and reads back 0
    end else if (araddr == REG_RULE_EN) begin
      rd_word[MATCH_RULES-1:0]   = rule_enable;
      rd_word[8 +: MATCH_RULES]  = trig_enable;
    end else if (araddr == REG_STATUS) begin
      rd_word[0]               = overflow;
      rd_word[8 +: LEVEL_BITS] = fifo_level;
    end else if (araddr >= REG_COUNT_BASE && rd_cnt_off < 8'(4 * MATCH_RULES)) begin
      rd_word[7:0] = match_counts[rd_cnt_off[4:2] * 8 +: 8];
    end else if (araddr >= REG_RULE_BASE && rd_rule_off[7:4] < 4'(MATCH_RULES)) begin
      case (rd_rule_off[3:2])
        2'd0:    rd_word = pattern_q[rd_rule_off[6:4]][31:0];
        2'd1:    rd_word = pattern_q[rd_rule_off[6:4]][BUFFER_BITS-1:32];
        2'd2:    rd_word = mask_q[rd_rule_off[6:4]][31:0];
        default: rd_word = mask_q[rd_rule_off[6:4]][BUFFER_BITS-1:32];
      endcase
    end
  end

  // read channel
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= !arready && !rvalid && arvalid;
      if (rd_en) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge fe_clk) begin
    if (rd_en) begin
      rdata <= rd_word;  // held until rready
    end
  end

  for (genvar g = 0; g < MATCH_RULES; g++) begin : g_rule_out
    assign patterns[g*BUFFER_BITS +: BUFFER_BITS] = pattern_q[g];
    assign masks[g*BUFFER_BITS +: BUFFER_BITS]    = mask_q[g];
  end

endmodule

//--- trace_top.sv
// trace_top: trace pattern-match capture front end, register slave beside a three stage pipe
`timescale 1ns/1ps

module trace_top #(
  parameter int BUFFER_BITS = 64,
  parameter int MATCH_RULES = 8,
  parameter int DELTA_WIDTH = 13,
  parameter int FIFO_DEPTH  = 16
) (
  input  logic        fe_clk,
  input  logic        reset,
  input  logic [7:0]  trace_byte,
  input  logic        trace_valid,
  input  logic        awvalid,
  output logic        awready,
  input  logic [7:0]  awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  output logic        bvalid,
  input  logic        bready,
  output logic [1:0]  bresp,
  input  logic        arvalid,
  output logic        arready,
  input  logic [7:0]  araddr,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rec_valid,
  input  logic        rec_ready,
  output logic [17:0] rec_data,
  output logic        trig_out
);
  import trace_pkg::*;

  logic                               arm;
  logic                               arm_start;
  logic                               clear_overflow;
  logic                               overflow;
  logic [MATCH_RULES-1:0]             rule_enable;
  logic [MATCH_RULES-1:0]             trig_enable;
  logic [MATCH_RULES*BUFFER_BITS-1:0] patterns;
  logic [MATCH_RULES*BUFFER_BITS-1:0] masks;
  logic [MATCH_RULES*8-1:0]           match_counts;
  logic [MATCH_RULES-1:0]             match_vec;
  logic [$clog2(FIFO_DEPTH):0]        fifo_level;
  logic                               rec_wr;
  fe_record_t                         rec_word;

  trace_regs #(
    .BUFFER_BITS (BUFFER_BITS),
    .MATCH_RULES (MATCH_RULES),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) u_regs (
    .fe_clk, .reset,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .match_counts, .overflow, .fifo_level,
    .arm, .clear_overflow, .rule_enable, .trig_enable, .patterns, .masks
  );

  // stage 1
  pattern_matcher #(
    .BUFFER_BITS (BUFFER_BITS),
    .MATCH_RULES (MATCH_RULES)
  ) u_matcher (
    .fe_clk, .reset, .trace_byte, .trace_valid, .arm, .rule_enable, .patterns, .masks,
    .match_vec, .match_counts, .arm_start
  );

  // stage 2
  event_recorder #(
    .MATCH_RULES (MATCH_RULES),
    .DELTA_WIDTH (DELTA_WIDTH)
  ) u_recorder (
    .fe_clk, .reset, .match_vec, .arm, .arm_start, .trig_enable,
    .rec_wr, .rec_word, .trig_out
  );

  // stage 3
  record_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .fe_clk, .reset, .rec_wr, .rec_word, .rec_ready, .clear_overflow,
    .rec_valid, .rec_data, .fifo_level, .overflow
  );

endmodule
